// File: alu_unit.sv
`timescale 1ns/1ps

module alu_unit import commit_pkg::*; import exec_op_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue_valid,
    output logic                             issue_ready,
    input  logic [UUID_WIDTH-1:0]            issue_uuid,
    input  logic [NW_WIDTH-1:0]              issue_wid,
    input  logic [NUM_THREADS-1:0]           issue_tmask,
    input  logic [NR_BITS-1:0]               issue_rd,
    input  issue_op_u                        issue_op,
    input  logic [NUM_THREADS-1:0][XLEN-1:0] issue_a,
    input  logic [NUM_THREADS-1:0][XLEN-1:0] issue_b,
    commit_if.producer                       commit_out
);

    alu_view_t       op;
    logic [XLEN-1:0] imm_ext;
    logic            issue_fire;
    commit_rec_t     result;
    logic            out_valid;
    commit_rec_t     out_data;

    assign op      = issue_op.alu;
    assign imm_ext = {{(XLEN-12){op.imm[11]}}, op.imm};

    // one-deep output, accepts when empty or being drained
    assign issue_ready = !out_valid || commit_out.ready;
    assign issue_fire  = issue_valid && issue_ready;

    always_comb begin
        logic [XLEN-1:0] b_eff;
        b_eff        = '0;
        result.uuid  = issue_uuid;
        result.wid   = issue_wid;
        result.tmask = issue_tmask;
        result.wb    = op.wb;
        result.rd    = issue_rd;
        result.data  = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            b_eff = op.use_imm ? issue_b[t] + imm_ext : issue_b[t];
            // inactive threads stay at zero
            if (issue_tmask[t]) begin
                case (op.fn)
                    ALU_ADD: result.data[t] = issue_a[t] + b_eff;
                    ALU_SUB: result.data[t] = issue_a[t] - b_eff;
                    ALU_AND: result.data[t] = issue_a[t] & b_eff;
                    ALU_XOR: result.data[t] = issue_a[t] ^ b_eff;
                    default: result.data[t] = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (issue_fire) begin
            out_valid <= 1'b1;
        end else if (commit_out.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            out_data <= result;
        end
    end

    assign commit_out.valid = out_valid;
    assign commit_out.data  = out_data;

endmodule

// File: commit_arb.sv
`timescale 1ns/1ps

module commit_arb import commit_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    commit_if.consumer in_alu,
    commit_if.consumer in_lsu,
    commit_if.producer out
);

    logic        last_lsu;
    logic        pick_lsu;
    logic        out_free;
    logic        take;
    logic        out_valid;
    commit_rec_t out_data;

    // output slot can load when empty or being drained
    assign out_free = !out_valid || out.ready;

    // round robin, last winner loses a tie
    always_comb begin
        if (in_alu.valid && in_lsu.valid) begin
            pick_lsu = !last_lsu;
        end else begin
            pick_lsu = in_lsu.valid;
        end
    end

    assign in_alu.ready = out_free && !pick_lsu;
    assign in_lsu.ready = out_free && pick_lsu;
    assign take         = out_free && (in_alu.valid || in_lsu.valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            // lsu marked as last so alu wins first tie
            last_lsu  <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            if (take) begin
                last_lsu  <= pick_lsu;
                out_valid <= 1'b1;
            end else if (out.ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= pick_lsu ? in_lsu.data : in_alu.data;
        end
    end

    assign out.valid = out_valid;
    assign out.data  = out_data;

endmodule

// File: commit_if.sv
`timescale 1ns/1ps

interface commit_if import commit_pkg::*; ();

    logic        valid;
    logic        ready;
    commit_rec_t data;

    // unit or arbiter side that owns the record
    modport producer (
        output valid,
        output data,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: commit_pkg.sv
package commit_pkg;

    // core sizes
    localparam int NUM_THREADS = 4;
    localparam int NUM_WARPS   = 4;
    localparam int NW_WIDTH    = $clog2(NUM_WARPS);
    localparam int XLEN        = 32;
    localparam int NR_BITS     = 5;
    localparam int UUID_WIDTH  = 8;

    // one finished instruction leaving an execution unit
    typedef struct packed {
        logic [UUID_WIDTH-1:0]             uuid;
        logic [NW_WIDTH-1:0]               wid;
        logic [NUM_THREADS-1:0]            tmask;
        logic                              wb;
        logic [NR_BITS-1:0]                rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]  data;
    } commit_rec_t;

    // register file writeback view
    typedef struct packed {
        logic [UUID_WIDTH-1:0]             uuid;
        logic [NW_WIDTH-1:0]               wid;
        logic [NUM_THREADS-1:0]            tmask;
        logic [NR_BITS-1:0]                rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]  data;
    } wb_rec_t;

endpackage

// File: commit_stage.sv
`timescale 1ns/1ps

module commit_stage import commit_pkg::*; #(
    parameter int PERF_CTR_BITS = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    commit_if.consumer               commit_in,
    output logic                     wb_valid,
    output wb_rec_t                  wb_data,
    output logic                     committed,
    output logic [NW_WIDTH-1:0]      committed_wid,
    output logic [PERF_CTR_BITS-1:0] instret
);

    localparam int SIZEW = $clog2(NUM_THREADS + 1);

    logic             commit_fire;
    logic [SIZEW-1:0] commit_size;
    logic             fire_r;
    logic [SIZEW-1:0] commit_size_r;

    // commit never stalls
    assign commit_in.ready = 1'b1;
    assign commit_fire     = commit_in.valid && commit_in.ready;

    // writeback only for records with a destination
    assign wb_valid      = commit_in.valid && commit_in.data.wb;
    assign wb_data.uuid  = commit_in.data.uuid;
    assign wb_data.wid   = commit_in.data.wid;
    assign wb_data.tmask = commit_in.data.tmask;
    assign wb_data.rd    = commit_in.data.rd;
    assign wb_data.data  = commit_in.data.data;

    // scheduler completion pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            committed <= 1'b0;
        end else begin
            committed <= commit_fire;
        end
    end

    always_ff @(posedge clk) begin
        committed_wid <= commit_in.data.wid;
    end

    // active threads in this commit
    always_comb begin
        commit_size = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            commit_size = commit_size + SIZEW'(commit_in.data.tmask[t]);
        end
    end

    // first stage holds the count
    always_ff @(posedge clk) begin
        if (reset) begin
            fire_r <= 1'b0;
        end else begin
            fire_r <= commit_fire;
        end
    end

    always_ff @(posedge clk) begin
        commit_size_r <= commit_size;
    end

    // second stage accumulates, stores included
    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (fire_r) begin
            instret <= instret + PERF_CTR_BITS'(commit_size_r);
        end
    end

endmodule

// File: exec_op_pkg.sv
package exec_op_pkg;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_e;

    // alu reading of the op word
    typedef struct packed {
        alu_op_e     fn;
        logic        wb;
        // imm is added to operand b when set
        logic        use_imm;
        logic [11:0] imm;
    } alu_view_t;

    // lsu reading of the op word
    typedef struct packed {
        logic        store;
        logic        wb;
        logic [1:0]  rsvd;
        // word offset, zero extended
        logic [11:0] offset;
    } lsu_view_t;

    // one op word, decoded differently by each unit
    typedef union packed {
        alu_view_t alu;
        lsu_view_t lsu;
    } issue_op_u;

endpackage

// File: gpu_commit_top.sv
`timescale 1ns/1ps

module gpu_commit_top import commit_pkg::*; import exec_op_pkg::*; #(
    parameter int LSU_DEPTH     = 16,
    parameter int PERF_CTR_BITS = 32
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             alu_valid,
    input  logic                             lsu_valid,
    output logic                             alu_ready,
    output logic                             lsu_ready,
    input  logic [UUID_WIDTH-1:0]            issue_uuid,
    input  logic [NW_WIDTH-1:0]              issue_wid,
    input  logic [NUM_THREADS-1:0]           issue_tmask,
    input  logic [NR_BITS-1:0]               issue_rd,
    input  issue_op_u                        issue_op,
    input  logic [NUM_THREADS-1:0][XLEN-1:0] issue_a,
    input  logic [NUM_THREADS-1:0][XLEN-1:0] issue_b,
    output logic                             wb_valid,
    output wb_rec_t                          wb_data,
    output logic                             committed,
    output logic [NW_WIDTH-1:0]              committed_wid,
    output logic [PERF_CTR_BITS-1:0]         instret
);

    commit_if alu_commit ();
    commit_if lsu_commit ();
    commit_if arb_commit ();

    alu_unit alu_unit_i (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (alu_valid),
        .issue_ready (alu_ready),
        .issue_uuid  (issue_uuid),
        .issue_wid   (issue_wid),
        .issue_tmask (issue_tmask),
        .issue_rd    (issue_rd),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .commit_out  (alu_commit)
    );

    lsu_unit #(
        .LSU_DEPTH (LSU_DEPTH)
    ) lsu_unit_i (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (lsu_valid),
        .issue_ready (lsu_ready),
        .issue_uuid  (issue_uuid),
        .issue_wid   (issue_wid),
        .issue_tmask (issue_tmask),
        .issue_rd    (issue_rd),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .commit_out  (lsu_commit)
    );

    // shared commit path
    commit_arb commit_arb_i (
        .clk    (clk),
        .reset  (reset),
        .in_alu (alu_commit),
        .in_lsu (lsu_commit),
        .out    (arb_commit)
    );

    commit_stage #(
        .PERF_CTR_BITS (PERF_CTR_BITS)
    ) commit_stage_i (
        .clk           (clk),
        .reset         (reset),
        .commit_in     (arb_commit),
        .wb_valid      (wb_valid),
        .wb_data       (wb_data),
        .committed     (committed),
        .committed_wid (committed_wid),
        .instret       (instret)
    );

endmodule

// File: lsu_unit.sv
`timescale 1ns/1ps

module lsu_unit import commit_pkg::*; import exec_op_pkg::*; #(
    parameter int LSU_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue_valid,
    output logic                             issue_ready,
    input  logic [UUID_WIDTH-1:0]            issue_uuid,
    input  logic [NW_WIDTH-1:0]              issue_wid,
    input  logic [NUM_THREADS-1:0]           issue_tmask,
    input  logic [NR_BITS-1:0]               issue_rd,
    input  issue_op_u                        issue_op,
    input  logic [NUM_THREADS-1:0][XLEN-1:0] issue_a,
    input  logic [NUM_THREADS-1:0][XLEN-1:0] issue_b,
    commit_if.producer                       commit_out
);

    localparam int AW = (LSU_DEPTH > 1) ? $clog2(LSU_DEPTH) : 1;

    lsu_view_t                      op;
    logic [XLEN-1:0]                mem [LSU_DEPTH];
    logic                           s1_valid;
    logic                           s1_store;
    commit_rec_t                    s1_rec;
    logic [NUM_THREADS-1:0][AW-1:0] s1_addr;
    logic                           s2_valid;
    commit_rec_t                    s2_rec;
    logic                           s2_ready;
    logic                           s1_adv;
    logic                           issue_fire;

    assign op = issue_op.lsu;

    // each stage moves when the next one is empty or draining
    assign s2_ready    = !s2_valid || commit_out.ready;
    assign s1_adv      = s1_valid && s2_ready;
    assign issue_ready = !s1_valid || s2_ready;
    assign issue_fire  = issue_valid && issue_ready;

    // address stage, data field carries the store value
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (issue_fire) begin
            s1_valid <= 1'b1;
        end else if (s1_adv) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            s1_store     <= op.store;
            s1_rec.uuid  <= issue_uuid;
            s1_rec.wid   <= issue_wid;
            s1_rec.tmask <= issue_tmask;
            s1_rec.wb    <= op.wb && !op.store;
            s1_rec.rd    <= issue_rd;
            s1_rec.data  <= issue_b;
            for (int t = 0; t < NUM_THREADS; t++) begin
                s1_addr[t] <= AW'((issue_a[t] + XLEN'(op.offset)) % LSU_DEPTH);
            end
        end
    end

    // store commits to memory as it leaves the address stage
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LSU_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (s1_adv && s1_store) begin
            // later threads overwrite earlier ones on collision
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (s1_rec.tmask[t]) begin
                    mem[s1_addr[t]] <= s1_rec.data[t];
                end
            end
        end
    end

    // memory stage
    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (s1_adv) begin
            s2_valid <= 1'b1;
        end else if (commit_out.ready) begin
            s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv) begin
            s2_rec.uuid  <= s1_rec.uuid;
            s2_rec.wid   <= s1_rec.wid;
            s2_rec.tmask <= s1_rec.tmask;
            s2_rec.wb    <= s1_rec.wb;
            s2_rec.rd    <= s1_rec.rd;
            for (int t = 0; t < NUM_THREADS; t++) begin
                s2_rec.data[t] <= (s1_rec.tmask[t] && !s1_store) ? mem[s1_addr[t]] : '0;
            end
        end
    end

    assign commit_out.valid = s2_valid;
    assign commit_out.data  = s2_rec;

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_gpu_commit -o tb_gpu_commit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_gpu_commit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

// File: sim.f
commit_pkg.sv
exec_op_pkg.sv
commit_if.sv
alu_unit.sv
lsu_unit.sv
commit_arb.sv
commit_stage.sv
gpu_commit_top.sv
tb_gpu_commit.sv

// File: tb_gpu_commit.sv
`timescale 1ns/1ps

module tb_gpu_commit import commit_pkg::*; import exec_op_pkg::*; ();

    localparam int LSU_DEPTH      = 16;
    localparam int PERF_CTR_BITS  = 32;
    localparam int N_ALU          = 40;
    localparam int N_STORE        = 12;
    localparam int N_LOAD         = 12;
    localparam int N_CONTEND      = 40;
    localparam int N_ISSUES       = N_ALU + N_STORE + N_LOAD + N_CONTEND;
    localparam int TIMEOUT_CYCLES = 8 * N_ISSUES + 200;

    logic                             clk;
    logic                             reset;
    logic                             alu_valid;
    logic                             lsu_valid;
    logic                             alu_ready;
    logic                             lsu_ready;
    logic [UUID_WIDTH-1:0]            issue_uuid;
    logic [NW_WIDTH-1:0]              issue_wid;
    logic [NUM_THREADS-1:0]           issue_tmask;
    logic [NR_BITS-1:0]               issue_rd;
    issue_op_u                        issue_op;
    logic [NUM_THREADS-1:0][XLEN-1:0] issue_a;
    logic [NUM_THREADS-1:0][XLEN-1:0] issue_b;
    logic                             wb_valid;
    wb_rec_t                          wb_data;
    logic                             committed;
    logic [NW_WIDTH-1:0]              committed_wid;
    logic [PERF_CTR_BITS-1:0]         instret;

    // reference state
    logic [31:0]              lfsr;
    logic [XLEN-1:0]          model_mem [LSU_DEPTH];
    wb_rec_t                  exp_rec [1 << UUID_WIDTH];
    logic                     exp_pending [1 << UUID_WIDTH];
    int                       warp_issued [NUM_WARPS];
    int                       warp_committed [NUM_WARPS];
    int                       issue_count;
    int                       commit_count;
    int                       error_count;
    int                       check_total;
    int                       tests_run;
    int                       tests_failed;
    int                       cycle_count;
    logic [UUID_WIDTH-1:0]    next_uuid;
    logic [PERF_CTR_BITS-1:0] exp_instret;
    logic                     prev_wb;
    logic [NW_WIDTH-1:0]      prev_wid;
    logic [UUID_WIDTH-1:0]    prev_uuid;

    gpu_commit_top #(
        .LSU_DEPTH     (LSU_DEPTH),
        .PERF_CTR_BITS (PERF_CTR_BITS)
    ) dut_i (.*);

    always #20 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [NUM_THREADS-1:0][XLEN-1:0] rand_words(input int bits);
        logic [NUM_THREADS-1:0][XLEN-1:0] w;
        for (int t = 0; t < NUM_THREADS; t++) begin
            w[t] = rand_bits(bits);
        end
        return w;
    endfunction

    function automatic int popcount(input logic [NUM_THREADS-1:0] m);
        int n;
        n = 0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            n += int'(m[t]);
        end
        return n;
    endfunction

    function automatic int lsu_addr(input logic [XLEN-1:0] a, input logic [11:0] offset);
        logic [XLEN-1:0] sum;
        sum = a + {{(XLEN-12){1'b0}}, offset};
        return int'(sum % XLEN'(LSU_DEPTH));
    endfunction

    // expected writeback, loads read the model memory as of issue order
    function automatic wb_rec_t ref_result(
        input logic                             to_lsu,
        input issue_op_u                        op,
        input logic [UUID_WIDTH-1:0]            uuid,
        input logic [NW_WIDTH-1:0]              wid,
        input logic [NUM_THREADS-1:0]           tmask,
        input logic [NR_BITS-1:0]               rd,
        input logic [NUM_THREADS-1:0][XLEN-1:0] a,
        input logic [NUM_THREADS-1:0][XLEN-1:0] b
    );
        wb_rec_t         r;
        logic [XLEN-1:0] bv;
        r.uuid  = uuid;
        r.wid   = wid;
        r.tmask = tmask;
        r.rd    = rd;
        r.data  = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            bv = b[t];
            if (!to_lsu && op.alu.use_imm) begin
                bv = b[t] + {{(XLEN-12){op.alu.imm[11]}}, op.alu.imm};
            end
            if (tmask[t] && to_lsu) begin
                r.data[t] = op.lsu.store ? '0 : model_mem[lsu_addr(a[t], op.lsu.offset)];
            end else if (tmask[t]) begin
                case (op.alu.fn)
                    ALU_ADD: r.data[t] = a[t] + bv;
                    ALU_SUB: r.data[t] = a[t] - bv;
                    ALU_AND: r.data[t] = a[t] & bv;
                    ALU_XOR: r.data[t] = a[t] ^ bv;
                endcase
            end
        end
        return r;
    endfunction

    task automatic check_wb(input wb_rec_t got, input wb_rec_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR wb_data: uuid %h got %h expected %h", exp.uuid, got, exp);
        end
    endtask

    task automatic check_wid(input string name, input logic [NW_WIDTH-1:0] got,
                             input logic [NW_WIDTH-1:0] exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [PERF_CTR_BITS-1:0] got,
                               input logic [PERF_CTR_BITS-1:0] exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic issue_instr(input logic to_lsu, input issue_op_u op,
                               input logic [NUM_THREADS-1:0] tmask,
                               input logic [NUM_THREADS-1:0][XLEN-1:0] a,
                               input logic [NUM_THREADS-1:0][XLEN-1:0] b);
        logic exp_wb;
        issue_uuid  = next_uuid;
        issue_wid   = NW_WIDTH'(rand_bits(NW_WIDTH));
        issue_tmask = tmask;
        issue_rd    = NR_BITS'(rand_bits(NR_BITS));
        issue_op    = op;
        issue_a     = a;
        issue_b     = b;
        alu_valid   = !to_lsu;
        lsu_valid   = to_lsu;
        // ready depends only on unit state, so it is steady mid-cycle
        while (!(to_lsu ? lsu_ready : alu_ready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        exp_wb = to_lsu ? (op.lsu.wb && !op.lsu.store) : op.alu.wb;
        if (exp_wb) begin
            exp_rec[issue_uuid]     = ref_result(to_lsu, op, issue_uuid, issue_wid, tmask,
                                                 issue_rd, a, b);
            exp_pending[issue_uuid] = 1'b1;
        end
        // later threads overwrite earlier ones
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (to_lsu && op.lsu.store && tmask[t]) begin
                model_mem[lsu_addr(a[t], op.lsu.offset)] = b[t];
            end
        end
        warp_issued[issue_wid]++;
        exp_instret += PERF_CTR_BITS'(popcount(tmask));
        issue_count++;
        next_uuid++;
        @(negedge clk);
        alu_valid = 1'b0;
        lsu_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (commit_count < issue_count) begin
            @(posedge clk);
        end
        @(negedge clk);
        for (int u = 0; u < (1 << UUID_WIDTH); u++) begin
            if (exp_pending[u]) begin
                error_count++;
                exp_pending[u] = 1'b0;
                $display("writeback for uuid %h never arrived", u[UUID_WIDTH-1:0]);
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
    endtask

    // outputs sampled mid-cycle, each record holds one full cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (prev_wb && !committed) begin
                error_count++;
                $display("no completion pulse after writeback of uuid %h", prev_uuid);
            end else if (prev_wb) begin
                check_wid("committed_wid", committed_wid, prev_wid);
            end
            if (committed) begin
                commit_count++;
                warp_committed[committed_wid]++;
            end
            prev_wb = 1'b0;
            if (wb_valid && exp_pending[wb_data.uuid]) begin
                check_wb(wb_data, exp_rec[wb_data.uuid]);
                exp_pending[wb_data.uuid] = 1'b0;
                prev_wb   = 1'b1;
                prev_wid  = exp_rec[wb_data.uuid].wid;
                prev_uuid = wb_data.uuid;
            end else if (wb_valid) begin
                error_count++;
                $display("unexpected writeback of uuid %h, repeated or never issued",
                         wb_data.uuid);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d issues committed",
                     cycle_count, commit_count, issue_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        issue_op_u op;
        int        errs;
        clk         = 1'b0;
        reset       = 1'b1;
        alu_valid   = 1'b0;
        lsu_valid   = 1'b0;
        issue_uuid  = '0;
        issue_wid   = '0;
        issue_tmask = '0;
        issue_rd    = '0;
        issue_op    = '0;
        issue_a     = '0;
        issue_b     = '0;
        lfsr        = 32'h7d2d;
        next_uuid   = '0;
        exp_instret = '0;
        prev_wb     = 1'b0;
        prev_wid    = '0;
        prev_uuid   = '0;
        for (int i = 0; i < LSU_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        for (int u = 0; u < (1 << UUID_WIDTH); u++) begin
            exp_pending[u] = 1'b0;
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            warp_issued[w]    = 0;
            warp_committed[w] = 0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        errs = error_count;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("committed", committed, 1'b0);
        check_flag("alu_ready", alu_ready, 1'b1);
        check_flag("lsu_ready", lsu_ready, 1'b1);
        check_count("instret", instret, '0);
        report_test("reset", errs);

        errs = error_count;
        for (int i = 0; i < N_ALU; i++) begin
            op             = '0;
            op.alu.fn      = alu_op_e'(2'(rand_bits(2)));
            op.alu.wb      = 1'b1;
            op.alu.use_imm = rand_bits(1) != 0;
            op.alu.imm     = 12'(rand_bits(12));
            issue_instr(1'b0, op, NUM_THREADS'(rand_bits(NUM_THREADS)),
                        rand_words(32), rand_words(32));
        end
        wait_drain();
        report_test("alu", errs);

        // small addresses so threads and instructions collide
        errs = error_count;
        for (int i = 0; i < N_STORE + N_LOAD; i++) begin
            op            = '0;
            op.lsu.store  = i < N_STORE;
            op.lsu.wb     = (i >= N_STORE) || (rand_bits(1) != 0);
            op.lsu.offset = 12'(rand_bits(12));
            issue_instr(1'b1, op, NUM_THREADS'(rand_bits(NUM_THREADS)),
                        rand_words(4), rand_words(32));
        end
        wait_drain();
        report_test("lsu", errs);

        errs = error_count;
        for (int i = 0; i < N_CONTEND; i++) begin
            op = issue_op_u'(16'(rand_bits(16)));
            if (i % 2 == 1) begin
                op.lsu.rsvd = '0;
                issue_instr(1'b1, op, NUM_THREADS'(rand_bits(NUM_THREADS)),
                            rand_words(4), rand_words(32));
            end else begin
                issue_instr(1'b0, op, NUM_THREADS'(rand_bits(NUM_THREADS)),
                            rand_words(32), rand_words(32));
            end
        end
        wait_drain();
        report_test("contention", errs);

        // idle cycles so extra pulses would show up in the counts
        errs = error_count;
        repeat (4) @(negedge clk);
        check_count("committed pulses", PERF_CTR_BITS'(commit_count),
                    PERF_CTR_BITS'(issue_count));
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_count($sformatf("committed_wid %0d count", w),
                        PERF_CTR_BITS'(warp_committed[w]), PERF_CTR_BITS'(warp_issued[w]));
        end
        report_test("scheduler", errs);

        errs = error_count;
        repeat (4) @(negedge clk);
        check_count("instret", instret, exp_instret);
        report_test("counter", errs);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_total, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
